/* files.f */
ctrl_pkg.sv
pipeline_sequencer.sv
execute_unit.sv
memory_unit.sv
writeback_unit.sv
controller.sv
tb_controller.sv

/* Bender.yml */
package:
  name: controller

sources:
  - ctrl_pkg.sv
  - pipeline_sequencer.sv
  - execute_unit.sv
  - memory_unit.sv
  - writeback_unit.sv
  - controller.sv
  - target: test
    files:
      - tb_controller.sv

/* tb_controller.sv */
module tb_controller
    import ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_instr     = 400;
    localparam int first_issue = 3;
    localparam int last_cycle  = first_issue + n_instr + 3;
    localparam int cycle_limit = n_instr + 30;
    // cond 1110, opcode 1110000 is a no-op
    localparam instr_t nop_word = 32'hEE00_0000;

    logic       clk;
    logic       rst_n;
    instr_t     instr_in;
    word_t      status_reg;
    opcode_t    opcode_execute_unit;
    reg_idx_t   rn_execute_unit;
    reg_idx_t   rs_execute_unit;
    reg_idx_t   rm_execute_unit;
    imm5_t      imm5_execute_unit;
    exec_ctrl_t exec_ctrl;
    cond_t      cond_memory_unit;
    opcode_t    opcode_memory_unit;
    reg_idx_t   rd_memory_unit;
    shift_op_t  shift_op_memory_unit;
    imm12_t     imm12_memory_unit;
    word_t      imm_branch_memory_unit;
    mem_ctrl_t  mem_ctrl;
    logic       w_en_ldr;

    // model state, indexed by the cycle a word was driven in
    instr_t      issued [0:511];
    word_t       status_hist [0:511];
    bit          squashed [0:511];
    bit          passed [0:511];
    logic [31:0] lfsr_state;
    int          error_count;
    int          cycle_count = 0;

    controller DUT (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .instr_in              (instr_in),
        .status_reg            (status_reg),
        .opcode_execute_unit   (opcode_execute_unit),
        .rn_execute_unit       (rn_execute_unit),
        .rs_execute_unit       (rs_execute_unit),
        .rm_execute_unit       (rm_execute_unit),
        .imm5_execute_unit     (imm5_execute_unit),
        .exec_ctrl             (exec_ctrl),
        .cond_memory_unit      (cond_memory_unit),
        .opcode_memory_unit    (opcode_memory_unit),
        .rd_memory_unit        (rd_memory_unit),
        .shift_op_memory_unit  (shift_op_memory_unit),
        .imm12_memory_unit     (imm12_memory_unit),
        .imm_branch_memory_unit(imm_branch_memory_unit),
        .mem_ctrl              (mem_ctrl),
        .w_en_ldr              (w_en_ldr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return r;
    endfunction

    // register fields narrowed to r0..r3 so forwarding hits often
    function automatic instr_t make_word();
        instr_t   w;
        logic [3:0] c4;
        w  = '0;
        c4 = 4'(rand_bits(4));
        w[31:28] = c4[3] ? ((c4[2:0] == 3'd0) ? 4'hb : 4'he) : c4;
        w[27:21] = 7'(rand_bits(7));
        w[20]    = 1'(rand_bits(1));
        w[17:16] = 2'(rand_bits(2));
        w[13:12] = 2'(rand_bits(2));
        w[9:8]   = 2'(rand_bits(2));
        w[7:4]   = 4'(rand_bits(4));
        w[1:0]   = 2'(rand_bits(2));
        return w;
    endfunction

    function automatic word_t make_status();
        return {4'(rand_bits(4)), 28'(rand_bits(28))};
    endfunction

    function automatic logic cond_holds(cond_t c, word_t s);
        logic n, z, cy, v;
        n  = s[31];
        z  = s[30];
        cy = s[29];
        v  = s[28];
        case (c)
            4'b0000: return z;
            4'b0001: return ~z;
            4'b0010: return cy;
            4'b0011: return ~cy;
            4'b0100: return n;
            4'b0101: return ~n;
            4'b0110: return v;
            4'b0111: return ~v;
            4'b1110: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t branch_offset(instr_t w);
        word_t ext;
        ext = {{8{w[23]}}, w[23:0]};
        return ext << 2;
    endfunction

    function automatic fwd_sel_t fwd_source(reg_idx_t src, reg_idx_t mrd, logic mwr,
                                            reg_idx_t lrd, logic lwr);
        if (mwr && src == mrd) begin
            return 2'b01;
        end else if (lwr && src == lrd) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    function automatic exec_ctrl_t expect_exec_ctrl(instr_t w, reg_idx_t mrd, logic mwr,
                                                    reg_idx_t lrd, logic lwr);
        exec_ctrl_t e;
        logic [2:0] cls;
        cls = w[27:25];
        e = '0;
        e.sel_A_in     = fwd_source(w[19:16], mrd, mwr, lrd, lwr);
        e.sel_B_in     = fwd_source(w[3:0], mrd, mwr, lrd, lwr);
        e.sel_shift_in = fwd_source(w[11:8], mrd, mwr, lrd, lwr);
        e.en_A         = !(cls == 3'b100 || cls[2:1] == 2'b11);
        e.en_B         = (cls == 3'b000) || (cls == 3'b011);
        e.en_S         = (cls == 3'b000) && w[4];
        e.sel_shift    = (cls == 3'b000) && w[4];
        return e;
    endfunction

    function automatic mem_ctrl_t expect_mem_ctrl(instr_t w);
        mem_ctrl_t m;
        m = '0;
        case (w[27:25])
            3'b000, 3'b001: begin
                m.w_en1     = 1'b1;
                m.ALU_op    = w[23:21];
                m.en_status = w[20];
                m.sel_B     = (w[27:25] == 3'b001);
            end
            3'b010, 3'b011: begin
                m.sel_B           = 1'b1;
                m.sel_pre_indexed = w[24];
                m.mem_w_en        = (w[27:25] == 3'b011);
            end
            3'b100, 3'b101: begin
                m.load_pc        = 1'b1;
                m.sel_pc         = 2'b10;
                m.sel_branch_imm = 1'b1;
                m.sel_A          = 1'b1;
                m.sel_load_LR    = (w[27:25] == 3'b101);
                m.w_en1          = (w[27:25] == 3'b101);
            end
            default: m = '0;
        endcase
        return m;
    endfunction

    function automatic string test_name(int c, string what);
        return $sformatf("cycle %0d %s", c, what);
    endfunction

    task automatic report_mismatch(string name, string exp, string act);
        error_count++;
        $display("[FAIL] %s expected %s actual %s", name, exp, act);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_exec(string name, exec_ctrl_t exp, exec_ctrl_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_mem(string name, mem_ctrl_t exp, mem_ctrl_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_reg(string name, reg_idx_t exp, reg_idx_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_opcode(string name, opcode_t exp, opcode_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_cond(string name, cond_t exp, cond_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_imm5(string name, imm5_t exp, imm5_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_imm12(string name, imm12_t exp, imm12_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_shift(string name, shift_op_t exp, shift_op_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    // memory stage first, since its branch decision squashes the execute word
    task automatic check_cycle(int c);
        instr_t     mw, ew, lw;
        logic       m_valid, pass, taken, ldr_we;
        mem_ctrl_t  m_exp;
        exec_ctrl_t e_exp;
        m_valid = 1'b0;
        pass    = 1'b0;
        ldr_we  = 1'b0;
        m_exp   = '0;
        e_exp   = '0;
        mw = (c >= 2) ? issued[c-2] : '0;
        ew = (c >= 1) ? issued[c-1] : '0;
        lw = (c >= 4) ? issued[c-4] : '0;
        if (c >= first_issue + 2) begin
            m_valid     = !squashed[c-2];
            pass        = cond_holds(mw[31:28], status_hist[c]);
            passed[c-2] = pass;
            if (m_valid && pass) begin
                m_exp = expect_mem_ctrl(mw);
            end
        end
        // reset vector request
        if (c == 0) begin
            m_exp.load_pc = 1'b1;
            m_exp.sel_pc  = 2'b01;
        end
        taken = m_valid && pass && (mw[27:25] == 3'b100 || mw[27:25] == 3'b101);
        if (taken) begin
            squashed[c-1] = 1'b1;
            squashed[c]   = 1'b1;
            squashed[c+1] = 1'b1;
        end
        if (c >= first_issue + 4) begin
            ldr_we = !squashed[c-4] && passed[c-4] && (lw[27:25] == 3'b010);
        end
        if (c >= first_issue + 1 && !squashed[c-1]) begin
            e_exp = expect_exec_ctrl(ew, mw[15:12], m_exp.w_en1, lw[15:12], ldr_we);
        end
        if (c >= first_issue + 1) begin
            check_opcode(test_name(c, "exec opcode"), ew[27:21], opcode_execute_unit);
            check_reg(test_name(c, "rn"), ew[19:16], rn_execute_unit);
            check_reg(test_name(c, "rs"), ew[11:8], rs_execute_unit);
            check_reg(test_name(c, "rm"), ew[3:0], rm_execute_unit);
            check_imm5(test_name(c, "imm5"), ew[11:7], imm5_execute_unit);
        end
        if (c >= first_issue + 2) begin
            check_cond(test_name(c, "cond"), mw[31:28], cond_memory_unit);
            check_opcode(test_name(c, "mem opcode"), mw[27:21], opcode_memory_unit);
            check_reg(test_name(c, "rd"), mw[15:12], rd_memory_unit);
            check_shift(test_name(c, "shift_op"), mw[6:5], shift_op_memory_unit);
            check_imm12(test_name(c, "imm12"), mw[11:0], imm12_memory_unit);
            check_word(test_name(c, "imm_branch"), branch_offset(mw), imm_branch_memory_unit);
        end
        check_exec(test_name(c, "exec_ctrl"), e_exp, exec_ctrl);
        check_mem(test_name(c, "mem_ctrl"), m_exp, mem_ctrl);
        check_bit(test_name(c, "w_en_ldr"), ldr_we, w_en_ldr);
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_in    = '0;
        status_reg  = '0;
        lfsr_state  = 32'd20;
        error_count = 0;
        repeat (8) begin
            @(negedge clk);
            check_exec("reset exec_ctrl", '0, exec_ctrl);
            check_mem("reset mem_ctrl", '0, mem_ctrl);
            check_bit("reset w_en_ldr", 1'b0, w_en_ldr);
        end
        rst_n = 1'b1;
        for (int c = 0; c <= last_cycle; c++) begin
            @(negedge clk);
            issued[c]      = (c < first_issue + n_instr) ? make_word() : nop_word;
            status_hist[c] = make_status();
            instr_in       = issued[c];
            status_reg     = status_hist[c];
            // outputs settle well before the next rising edge
            #2;
            check_cycle(c);
        end
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* controller.sv */
module controller
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  instr_t     instr_in,
    input  word_t      status_reg,
    // execute stage
    output opcode_t    opcode_execute_unit,
    output reg_idx_t   rn_execute_unit,
    output reg_idx_t   rs_execute_unit,
    output reg_idx_t   rm_execute_unit,
    output imm5_t      imm5_execute_unit,
    output exec_ctrl_t exec_ctrl,
    // memory stage
    output cond_t      cond_memory_unit,
    output opcode_t    opcode_memory_unit,
    output reg_idx_t   rd_memory_unit,
    output shift_op_t  shift_op_memory_unit,
    output imm12_t     imm12_memory_unit,
    output word_t      imm_branch_memory_unit,
    output mem_ctrl_t  mem_ctrl,
    // load write-back
    output logic       w_en_ldr
);

    logic        en_execute;
    logic        en_memory;
    logic        en_mem_wait;
    logic        en_writeback;
    logic        start_pc_load;
    logic        branch_taken;
    stage_slot_t exec_slot;
    stage_slot_t mem_slot;
    reg_idx_t    ldr_rd;

    pipeline_sequencer pipeline_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .en_execute   (en_execute),
        .en_memory    (en_memory),
        .en_mem_wait  (en_mem_wait),
        .en_writeback (en_writeback),
        .start_pc_load(start_pc_load)
    );

    execute_unit execute_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_in    (instr_in),
        .enable      (en_execute),
        .branch_taken(branch_taken),
        // forwarding sources
        .mem_rd      (rd_memory_unit),
        .mem_writes  (mem_ctrl.w_en1),
        .ldr_rd      (ldr_rd),
        .w_en_ldr    (w_en_ldr),
        .opcode      (opcode_execute_unit),
        .rn          (rn_execute_unit),
        .rs          (rs_execute_unit),
        .rm          (rm_execute_unit),
        .imm5        (imm5_execute_unit),
        .exec_ctrl   (exec_ctrl),
        .slot        (exec_slot)
    );

    memory_unit memory_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_in      (exec_slot),
        .enable       (en_memory),
        .status_reg   (status_reg),
        .start_pc_load(start_pc_load),
        .cond         (cond_memory_unit),
        .opcode       (opcode_memory_unit),
        .rd           (rd_memory_unit),
        .shift_op     (shift_op_memory_unit),
        .imm12        (imm12_memory_unit),
        .imm_branch   (imm_branch_memory_unit),
        .mem_ctrl     (mem_ctrl),
        .branch_taken (branch_taken),
        .slot_out     (mem_slot)
    );

    writeback_unit writeback_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .slot_in     (mem_slot),
        .en_mem_wait (en_mem_wait),
        .en_writeback(en_writeback),
        .w_en_ldr    (w_en_ldr),
        .ldr_rd      (ldr_rd)
    );

endmodule

/* writeback_unit.sv */
module writeback_unit
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  stage_slot_t slot_in,
    input  logic        en_mem_wait,
    input  logic        en_writeback,
    output logic        w_en_ldr,
    output reg_idx_t    ldr_rd
);

    stage_slot_t wait_q;
    stage_slot_t wb_q;
    fields_t     f;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= '0;
            wb_q   <= '0;
        end else begin
            wait_q.instr <= slot_in.instr;
            wait_q.valid <= en_mem_wait & slot_in.valid;
            wait_q.pass  <= slot_in.pass;
            wb_q.instr   <= wait_q.instr;
            wb_q.valid   <= en_writeback & wait_q.valid;
            wb_q.pass    <= wait_q.pass;
        end
    end

    assign f = decode(wb_q.instr);

    // load data arrives from memory in this stage
    assign w_en_ldr = wb_q.valid & wb_q.pass & (instr_class(f.opcode) == cls_load);
    assign ldr_rd   = f.rd;

endmodule

/* memory_unit.sv */
module memory_unit
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  stage_slot_t slot_in,
    input  logic        enable,
    input  word_t       status_reg,
    input  logic        start_pc_load,
    output cond_t       cond,
    output opcode_t     opcode,
    output reg_idx_t    rd,
    output shift_op_t   shift_op,
    output imm12_t      imm12,
    output word_t       imm_branch,
    output mem_ctrl_t   mem_ctrl,
    output logic        branch_taken,
    output stage_slot_t slot_out
);

    instr_t     instr_q;
    logic       valid_q;
    fields_t    f;
    logic [2:0] cls;
    logic       cond_ok;
    logic       active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q <= '0;
            valid_q <= 1'b0;
        end else begin
            instr_q <= slot_in.instr;
            valid_q <= enable & slot_in.valid;
        end
    end

    assign f       = decode(instr_q);
    assign cls     = instr_class(f.opcode);
    assign cond_ok = cond_pass(f.cond, status_reg);
    assign active  = valid_q & cond_ok;

    assign cond       = f.cond;
    assign opcode     = f.opcode;
    assign rd         = f.rd;
    assign shift_op   = f.shift_op;
    assign imm12      = f.imm12;
    assign imm_branch = f.imm_branch;

    assign branch_taken = active & ((cls == cls_branch) || (cls == cls_branch_link));
    assign slot_out     = '{instr: instr_q, valid: valid_q, pass: cond_ok};

    always_comb begin
        mem_ctrl = '0;
        if (active) begin
            case (cls)
                cls_alu_reg, cls_alu_imm: begin
                    mem_ctrl.w_en1     = 1'b1;
                    mem_ctrl.ALU_op    = f.opcode[2:0];
                    mem_ctrl.en_status = f.set_flags;
                    mem_ctrl.sel_B     = (cls == cls_alu_imm);
                end
                // address is base plus offset
                cls_load, cls_store: begin
                    mem_ctrl.sel_B           = 1'b1;
                    mem_ctrl.sel_pre_indexed = f.opcode[3];
                    mem_ctrl.mem_w_en        = (cls == cls_store);
                end
                cls_branch, cls_branch_link: begin
                    mem_ctrl.load_pc        = 1'b1;
                    mem_ctrl.sel_pc         = pc_branch;
                    mem_ctrl.sel_branch_imm = 1'b1;
                    mem_ctrl.sel_A          = 1'b1;
                    // return address into LR
                    mem_ctrl.sel_load_LR    = (cls == cls_branch_link);
                    mem_ctrl.w_en1          = (cls == cls_branch_link);
                end
                default: mem_ctrl = '0;
            endcase
        end
        // reset vector load during start-up
        if (start_pc_load) begin
            mem_ctrl.load_pc = 1'b1;
            mem_ctrl.sel_pc  = pc_reset;
        end
    end

    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ctrl.mem_w_en && mem_ctrl.w_en1));

    a_pc_source: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ctrl.load_pc |-> mem_ctrl.sel_pc != pc_inc);

    // three dead slots follow every taken branch
    a_branch_shadow: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken |=> !valid_q [*3]);

endmodule

/* execute_unit.sv */
module execute_unit
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  instr_t      instr_in,
    input  logic        enable,
    input  logic        branch_taken,
    input  reg_idx_t    mem_rd,
    input  logic        mem_writes,
    input  reg_idx_t    ldr_rd,
    input  logic        w_en_ldr,
    output opcode_t     opcode,
    output reg_idx_t    rn,
    output reg_idx_t    rs,
    output reg_idx_t    rm,
    output imm5_t       imm5,
    output exec_ctrl_t  exec_ctrl,
    output stage_slot_t slot
);

    instr_t     instr_q;
    logic       valid_q;
    // squash shadow of the fetch side
    // bit 1 marks the word captured at the next edge, bit 0 the word now held
    logic [1:0] squash_q;
    fields_t    f;
    logic [2:0] cls;
    logic       live;

    // memory stage first, then the load in write-back
    function automatic fwd_sel_t fwd_pick(reg_idx_t src, reg_idx_t m_rd, logic m_wr,
                                          reg_idx_t l_rd, logic l_wr);
        if (m_wr && src == m_rd) begin
            return fwd_mem;
        end
        if (l_wr && src == l_rd) begin
            return fwd_ldr;
        end
        return fwd_regfile;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q  <= '0;
            valid_q  <= 1'b0;
            squash_q <= 2'b00;
        end else begin
            instr_q <= instr_in;
            valid_q <= enable & ~squash_q[1];
            if (branch_taken) begin
                squash_q <= 2'b11;
            end else begin
                squash_q <= {1'b0, squash_q[1]};
            end
        end
    end

    assign f   = decode(instr_q);
    assign cls = instr_class(f.opcode);

    // a taken branch kills the word held here in the same cycle
    assign live = valid_q & ~squash_q[0] & ~branch_taken;

    assign opcode = f.opcode;
    assign rn     = f.rn;
    assign rs     = f.rs;
    assign rm     = f.rm;
    assign imm5   = f.imm5;
    assign slot   = '{instr: instr_q, valid: live, pass: 1'b0};

    always_comb begin
        exec_ctrl = '0;
        if (live) begin
            exec_ctrl.sel_A_in     = fwd_pick(f.rn, mem_rd, mem_writes, ldr_rd, w_en_ldr);
            exec_ctrl.sel_B_in     = fwd_pick(f.rm, mem_rd, mem_writes, ldr_rd, w_en_ldr);
            exec_ctrl.sel_shift_in = fwd_pick(f.rs, mem_rd, mem_writes, ldr_rd, w_en_ldr);
            exec_ctrl.en_A         = (cls != cls_branch) && (cls != cls_nop);
            exec_ctrl.en_B         = (cls == cls_alu_reg) || (cls == cls_store);
            // shift amount taken from rs
            exec_ctrl.en_S         = (cls == cls_alu_reg) && f.reg_shift;
            exec_ctrl.sel_shift    = (cls == cls_alu_reg) && f.reg_shift;
        end
    end

    a_fwd_legal: assert property (@(posedge clk) disable iff (!rst_n)
        exec_ctrl.sel_A_in != 2'b11 && exec_ctrl.sel_B_in != 2'b11 &&
        exec_ctrl.sel_shift_in != 2'b11);

endmodule

/* pipeline_sequencer.sv */
module pipeline_sequencer
    import ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic en_execute,
    output logic en_memory,
    output logic en_mem_wait,
    output logic en_writeback,
    output logic start_pc_load
);

    seq_state_e state;

    // one pass through start-up, then stay in run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_reset_hold;
        end else begin
            case (state)
                st_reset_hold:    state <= st_load_pc_start;
                st_load_pc_start: state <= st_fetch;
                st_fetch:         state <= st_fetch_wait;
                st_fetch_wait:    state <= st_execute;
                st_execute:       state <= st_memory;
                st_memory:        state <= st_mem_wait;
                st_mem_wait:      state <= st_write_back;
                default:          state <= st_run;
            endcase
        end
    end

    // stages open one per cycle
    assign en_execute    = (state >= st_execute);
    assign en_memory     = (state >= st_memory);
    assign en_mem_wait   = (state >= st_mem_wait);
    assign en_writeback  = (state >= st_write_back);
    assign start_pc_load = (state == st_load_pc_start);

    property p_stays_open(logic en);
        @(posedge clk) disable iff (!rst_n) en |=> en;
    endproperty

    a_exec_open:  assert property (p_stays_open(en_execute));
    a_mem_open:   assert property (p_stays_open(en_memory));
    a_wait_open:  assert property (p_stays_open(en_mem_wait));
    a_wback_open: assert property (p_stays_open(en_writeback));

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  cond_t;
    typedef logic [4:0]  imm5_t;
    typedef logic [11:0] imm12_t;
    typedef logic [1:0]  shift_op_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;
    typedef logic [1:0]  pc_sel_t;

    // operand sources for the execute stage
    localparam fwd_sel_t fwd_regfile = 2'b00;
    localparam fwd_sel_t fwd_mem     = 2'b01;
    localparam fwd_sel_t fwd_ldr     = 2'b10;

    localparam pc_sel_t pc_inc    = 2'b00;
    localparam pc_sel_t pc_reset  = 2'b01;
    localparam pc_sel_t pc_branch = 2'b10;

    // instruction class, taken from opcode bits 6:4
    localparam logic [2:0] cls_alu_reg     = 3'b000;
    localparam logic [2:0] cls_alu_imm     = 3'b001;
    localparam logic [2:0] cls_load        = 3'b010;
    localparam logic [2:0] cls_store       = 3'b011;
    localparam logic [2:0] cls_branch      = 3'b100;
    localparam logic [2:0] cls_branch_link = 3'b101;
    localparam logic [2:0] cls_nop         = 3'b111;

    typedef enum logic [3:0] {
        st_reset_hold,
        st_load_pc_start,
        st_fetch,
        st_fetch_wait,
        st_execute,
        st_memory,
        st_mem_wait,
        st_write_back,
        st_run
    } seq_state_e;

    // pass is only meaningful from the memory stage on
    typedef struct packed {
        instr_t instr;
        logic   valid;
        logic   pass;
    } stage_slot_t;

    typedef struct packed {
        fwd_sel_t sel_A_in, sel_B_in, sel_shift_in;
        logic     sel_shift, en_A, en_B, en_S;
    } exec_ctrl_t;

    typedef struct packed {
        pc_sel_t sel_pc;
        logic    load_pc, sel_branch_imm, sel_A, sel_B;
        alu_op_t ALU_op;
        logic    sel_pre_indexed, en_status, sel_load_LR, w_en1, mem_w_en;
    } mem_ctrl_t;

    typedef struct packed {
        cond_t     cond;
        opcode_t   opcode;
        logic      set_flags;
        reg_idx_t  rn, rd, rs, rm;
        imm5_t     imm5;
        shift_op_t shift_op;
        logic      reg_shift;
        imm12_t    imm12;
        word_t     imm_branch;
    } fields_t;

    function automatic fields_t decode(instr_t i);
        fields_t f;
        f.cond       = i[31:28];
        f.opcode     = i[27:21];
        f.set_flags  = i[20];
        f.rn         = i[19:16];
        f.rd         = i[15:12];
        f.rs         = i[11:8];
        f.imm5       = i[11:7];
        f.shift_op   = i[6:5];
        f.reg_shift  = i[4];
        f.rm         = i[3:0];
        f.imm12      = i[11:0];
        // word offset, sign-extended
        f.imm_branch = {{6{i[23]}}, i[23:0], 2'b00};
        return f;
    endfunction

    // 110 and 111 both fold into no-op
    function automatic logic [2:0] instr_class(opcode_t op);
        return (op[6:4] > cls_branch_link) ? cls_nop : op[6:4];
    endfunction

    // flags sit at N=31, Z=30, C=29, V=28
    function automatic logic cond_pass(cond_t c, word_t status);
        case (c)
            4'h0: return status[30];
            4'h1: return !status[30];
            4'h2: return status[29];
            4'h3: return !status[29];
            4'h4: return status[31];
            4'h5: return !status[31];
            4'h6: return status[28];
            4'h7: return !status[28];
            4'he: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage
